// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary -j 0
TOP       = tb_video_display
FILELIST  = all.f
PASS_MSG  = TESTBENCH PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: all.f
video_pkg.sv
video_timing.sv
frame_buffer.sv
host_write_port.sv
pixel_out.sv
video_display_top.sv
tb_video_display.sv

// File: frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer (
	input  logic                    clock,
	input  logic                    we,
	input  video_pkg::pixel_write_t wr,
	input  video_pkg::fb_addr_t     rd_addr,
	output video_pkg::pixel_t       rd_data
);

	// One RGB565 word per visible pixel
	video_pkg::pixel_t mem [video_pkg::FB_DEPTH];

	////////////////////////////////////////////////////////////
	// Host side write
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (we) begin
			mem[wr.addr] <= wr.color;
		end
	end

	////////////////////////////////////////////////////////////
	// Video side read
	////////////////////////////////////////////////////////////

	// Registered read, data valid one clock after the address.
	// A write to the same word in the same clock is seen
	// only on the next read
	always_ff @(posedge clock) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// File: host_write_port.sv
`timescale 1ns/1ps

module host_write_port (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    req,
	input  video_pkg::pixel_write_t wr,
	output logic                    ack,
	output logic                    fb_we,
	output video_pkg::pixel_write_t fb_wr
);

	video_pkg::write_state_t state;
	logic                    take;

	// New request seen while idle
	assign take = (state == video_pkg::WAIT_REQ) && req;

	// ack follows the state directly
	assign ack = (state == video_pkg::HOLD_ACK);

	////////////////////////////////////////////////////////////
	// Handshake FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			state <= video_pkg::WAIT_REQ;
			fb_we <= 1'b0;
		end else begin
			fb_we <= take;
			case (state)
				video_pkg::WAIT_REQ: begin
					if (req) begin
						state <= video_pkg::HOLD_ACK;
					end
				end
				video_pkg::HOLD_ACK: begin
					// Host has seen ack and let go
					if (!req) begin
						state <= video_pkg::WAIT_REQ;
					end
				end
				default: state <= video_pkg::WAIT_REQ;
			endcase
		end
	end

	// Write payload, captured once per handshake
	always_ff @(posedge clock) begin
		if (take) begin
			fb_wr <= wr;
		end
	end

endmodule

// File: pixel_out.sv
`timescale 1ns/1ps

module pixel_out (
	input  logic                clock,
	input  logic                rst_n,
	input  video_pkg::scan_t    scan,
	output video_pkg::fb_addr_t rd_addr,
	input  video_pkg::pixel_t   rd_data,
	output logic                hsync,
	output logic                vsync,
	output logic [4:0]          red,
	output logic [5:0]          green,
	output logic [4:0]          blue
);

	// Scan state lined up with the RAM read
	video_pkg::scan_t scan_d;

	////////////////////////////////////////////////////////////
	// Address and flag delay
	////////////////////////////////////////////////////////////

	// Raster order, row major, latched by the RAM read register
	always_comb begin
		rd_addr = video_pkg::fb_addr_t'(scan.row) * video_pkg::fb_addr_t'(video_pkg::H_ACTIVE)
			+ video_pkg::fb_addr_t'(scan.col);
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			scan_d        <= '0;
			scan_d.hsync  <= 1'b1;
			scan_d.vsync  <= 1'b1;
		end else begin
			scan_d <= scan;
		end
	end

	////////////////////////////////////////////////////////////
	// Blanking and output registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			hsync               <= 1'b1;
			vsync               <= 1'b1;
			{red, green, blue}  <= '0;
		end else begin
			hsync <= scan_d.hsync;
			vsync <= scan_d.vsync;
			// Black outside the picture
			{red, green, blue} <= scan_d.active ? rd_data : '0;
		end
	end

endmodule

// File: tb_video_display.sv
`timescale 1ns/1ps

module tb_video_display;

	logic                    clock;
	logic                    rst_n;
	logic                    req;
	video_pkg::pixel_write_t wr;
	logic                    ack;
	logic                    hsync;
	logic                    vsync;
	logic [4:0]              red;
	logic [5:0]              green;
	logic [4:0]              blue;

	video_pkg::pixel_t model [video_pkg::FB_DEPTH];
	logic [31:0]       rng_state = 32'h433c_02e1;
	int                value_errors = 0;
	int                other_errors = 0;
	int                cycles = 0;
	int                cycle_limit = 0;

	// Commands from the tests file
	string             cmd_kind [$];
	string             cmd_name [$];
	int                cmd_addr [$];
	int                cmd_color [$];

	video_display_top i_dut (
		.clock (clock),
		.rst_n (rst_n),
		.req   (req),
		.wr    (wr),
		.ack   (ack),
		.hsync (hsync),
		.vsync (vsync),
		.red   (red),
		.green (green),
		.blue  (blue)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycle_limit != 0 && cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////

	task automatic check_pixel(input string name, input video_pkg::pixel_t exp,
		input video_pkg::pixel_t act);
		if (exp !== act) begin
			$display("error %s: expected %h actual %h", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_sync_width(input string name, input video_pkg::hcount_t exp,
		input video_pkg::hcount_t act);
		if (exp !== act) begin
			$display("error %s: expected %0d clocks actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_line_count(input string name, input video_pkg::vcount_t exp,
		input video_pkg::vcount_t act);
		if (exp !== act) begin
			$display("error %s: expected %0d lines actual %0d", name, exp, act);
			value_errors++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Host handshake and frame capture
	////////////////////////////////////////////////////////////

	task automatic write_pixel(input string name, input int addr, input int color);
		int n;
		@(negedge clock);
		wr.addr  = video_pkg::fb_addr_t'(addr);
		wr.color = video_pkg::pixel_t'(color);
		req      = 1'b1;
		n = 0;
		while (!ack && n < 8) begin
			@(negedge clock);
			n++;
		end
		if (!ack) begin
			$display("%s: ack did not rise within 8 cycles of req", name);
			other_errors++;
		end
		model[addr] = video_pkg::pixel_t'(color);
		req = 1'b0;
		n = 0;
		while (ack && n < 8) begin
			@(negedge clock);
			n++;
		end
		if (ack) begin
			$display("%s: ack stayed high 8 cycles after req dropped", name);
			other_errors++;
		end
	endtask

	task automatic check_frame(input string name);
		int                frame_len;
		int                h;
		int                l;
		int                last_fall;
		int                low_run;
		int                line_falls;
		int                vlow_lines;
		logic              prev_h;
		logic              prev_v;
		video_pkg::pixel_t exp;
		frame_len  = int'(video_pkg::H_TOTAL) * int'(video_pkg::V_TOTAL);
		last_fall  = 0;
		low_run    = 0;
		line_falls = 0;
		vlow_lines = 0;
		prev_h     = 1'b1;
		prev_v     = vsync;
		@(negedge clock);
		while (!(prev_v && !vsync)) begin
			prev_v = vsync;
			@(negedge clock);
		end
		for (int t = 0; t <= frame_len; t++) begin
			if (t > 0) begin
				@(negedge clock);
			end
			if (t == frame_len) begin
				if (!(prev_v && !vsync)) begin
					$display("%s: vsync did not fall again after one frame", name);
					other_errors++;
				end
				check_line_count({name, " lines"}, video_pkg::V_TOTAL,
					video_pkg::vcount_t'(line_falls));
				check_line_count({name, " vsync low"}, video_pkg::V_SYNC,
					video_pkg::vcount_t'(vlow_lines));
				break;
			end
			if (prev_h && !hsync) begin
				if (t > 0) begin
					check_sync_width({name, " hsync period"}, video_pkg::H_TOTAL,
						video_pkg::hcount_t'(t - last_fall));
				end
				last_fall = t;
				line_falls++;
				if (!vsync) begin
					vlow_lines++;
				end
			end
			if (!prev_h && hsync) begin
				check_sync_width({name, " hsync low"}, video_pkg::H_SYNC,
					video_pkg::hcount_t'(low_run));
				low_run = 0;
			end
			if (!hsync) begin
				low_run++;
			end
			// Position relative to the vsync falling edge
			h = t % int'(video_pkg::H_TOTAL);
			l = t / int'(video_pkg::H_TOTAL);
			exp = '0;
			if (h >= int'(video_pkg::H_ACT_START) && h < int'(video_pkg::H_ACT_END)
				&& l >= int'(video_pkg::V_ACT_START) && l < int'(video_pkg::V_ACT_END)) begin
				exp = model[(l - int'(video_pkg::V_ACT_START)) * int'(video_pkg::H_ACTIVE)
					+ h - int'(video_pkg::H_ACT_START)];
			end
			check_pixel($sformatf("%s line %0d clock %0d", name, l, h), exp,
				{red, green, blue});
			prev_h = hsync;
			prev_v = vsync;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////

	initial begin
		int    fd;
		int    r;
		int    a;
		int    c;
		string kind;
		string name;
		string rest;
		rst_n = 1'b0;
		req   = 1'b0;
		wr    = '0;
		fd = $fopen("video_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open the tests file video_tests.txt");
			other_errors++;
		end else begin
			while (!$feof(fd)) begin
				r = $fscanf(fd, " %s", kind);
				if (r != 1) begin
					break;
				end
				if (kind.substr(0, 0) == "#") begin
					r = $fgets(rest, fd);
				end else if (kind == "write") begin
					r = $fscanf(fd, " %s %h %h", name, a, c);
					cmd_kind.push_back(kind);
					cmd_name.push_back(name);
					cmd_addr.push_back(a);
					cmd_color.push_back(c);
				end else begin
					r = $fscanf(fd, " %s", name);
					cmd_kind.push_back(kind);
					cmd_name.push_back(name);
					cmd_addr.push_back(0);
					cmd_color.push_back(0);
				end
			end
			$fclose(fd);
		end
		cycle_limit = (cmd_kind.size() + 1) * int'(video_pkg::H_TOTAL)
			* int'(video_pkg::V_TOTAL) * 2 + video_pkg::FB_DEPTH * 8 + 16;

		repeat (3) @(negedge clock);
		rst_n = 1'b1;
		// State right after reset before any clock edge
		if (hsync !== 1'b1 || vsync !== 1'b1 || ack !== 1'b0) begin
			$display("after reset: sync not high or ack not low");
			other_errors++;
		end
		check_pixel("reset colour", '0, {red, green, blue});

		for (int i = 0; i < video_pkg::FB_DEPTH; i++) begin
			write_pixel("fill", i, int'(lcg_next() >> 16));
		end

		foreach (cmd_kind[i]) begin
			if (cmd_kind[i] == "write") begin
				write_pixel(cmd_name[i], cmd_addr[i], cmd_color[i]);
			end else if (cmd_kind[i] == "frame") begin
				check_frame(cmd_name[i]);
			end else begin
				$display("unknown command %s in the tests file", cmd_kind[i]);
				other_errors++;
			end
		end

		$display("errors: %0d wrong values, %0d other failures", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

// File: video_display_top.sv
`timescale 1ns/1ps

module video_display_top (
	input  logic                    clock,
	input  logic                    rst_n,
	input  logic                    req,
	input  video_pkg::pixel_write_t wr,
	output logic                    ack,
	output logic                    hsync,
	output logic                    vsync,
	output logic [4:0]              red,
	output logic [5:0]              green,
	output logic [4:0]              blue
);

	video_pkg::scan_t        scan;
	video_pkg::fb_addr_t     rd_addr;
	video_pkg::pixel_t       rd_data;
	logic                    fb_we;
	video_pkg::pixel_write_t fb_wr;

	video_timing i_timing (
		.clock (clock),
		.rst_n (rst_n),
		.scan  (scan)
	);

	// Host write path
	host_write_port i_host (
		.clock (clock),
		.rst_n (rst_n),
		.req   (req),
		.wr    (wr),
		.ack   (ack),
		.fb_we (fb_we),
		.fb_wr (fb_wr)
	);

	frame_buffer i_fb (
		.clock   (clock),
		.we      (fb_we),
		.wr      (fb_wr),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	// Video output path
	pixel_out i_pixel (
		.clock   (clock),
		.rst_n   (rst_n),
		.scan    (scan),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.hsync   (hsync),
		.vsync   (vsync),
		.red     (red),
		.green   (green),
		.blue    (blue)
	);

endmodule

// File: video_pkg.sv
package video_pkg;

	////////////////////////////////////////////////////////////
	// Counter widths
	////////////////////////////////////////////////////////////

	// Horizontal count and visible column
	typedef logic [4:0] hcount_t;

	// Vertical count and visible row
	typedef logic [3:0] vcount_t;

	////////////////////////////////////////////////////////////
	// Scaled-down video mode
	////////////////////////////////////////////////////////////

	// Horizontal intervals in pixel clocks
	localparam hcount_t H_SYNC   = 5'd4;
	localparam hcount_t H_BACK   = 5'd3;
	localparam hcount_t H_ACTIVE = 5'd16;
	localparam hcount_t H_FRONT  = 5'd2;
	localparam hcount_t H_TOTAL  = H_SYNC + H_BACK + H_ACTIVE + H_FRONT;

	// Vertical intervals in lines
	localparam vcount_t V_SYNC   = 4'd2;
	localparam vcount_t V_BACK   = 4'd1;
	localparam vcount_t V_ACTIVE = 4'd8;
	localparam vcount_t V_FRONT  = 4'd1;
	localparam vcount_t V_TOTAL  = V_SYNC + V_BACK + V_ACTIVE + V_FRONT;

	// Active window, end is exclusive
	localparam hcount_t H_ACT_START = H_SYNC + H_BACK;
	localparam hcount_t H_ACT_END   = H_ACT_START + H_ACTIVE;
	localparam vcount_t V_ACT_START = V_SYNC + V_BACK;
	localparam vcount_t V_ACT_END   = V_ACT_START + V_ACTIVE;

	// One word per visible pixel
	localparam int FB_DEPTH = int'(H_ACTIVE) * int'(V_ACTIVE);

	////////////////////////////////////////////////////////////
	// Pixel data and shared records
	////////////////////////////////////////////////////////////

	typedef logic [$clog2(FB_DEPTH)-1:0] fb_addr_t;

	// RGB565, red on top
	typedef logic [15:0] pixel_t;

	typedef struct packed {
		fb_addr_t addr;
		pixel_t   color;
	} pixel_write_t;

	// Scan state of one clock
	typedef struct packed {
		hcount_t col;
		vcount_t row;
		logic    active;
		logic    hsync;
		logic    vsync;
	} scan_t;

	typedef enum logic {
		WAIT_REQ,
		HOLD_ACK
	} write_state_t;

endpackage

// File: video_tests.txt
# write <name> <addr hex> <color hex RGB565>
# frame <name>
frame after_fill
frame second_frame
write corner_first 00 f800
write corner_last 7f 001f
frame corners
write row1_start 10 07e0
write row1_end 1f ffff
write mid 45 1234
frame rows
write overwrite_mid 45 abcd
frame overwrite
write black_pixel 20 0000
write white_pixel 21 ffff
write row7_start 70 8410
frame mixed
write corner_first_again 00 0001
frame final

// File: video_timing.sv
`timescale 1ns/1ps

module video_timing (
	input  logic                clock,
	input  logic                rst_n,
	output video_pkg::scan_t    scan
);

	video_pkg::hcount_t hcount;
	video_pkg::vcount_t vcount;
	video_pkg::hcount_t h_next;
	video_pkg::vcount_t v_next;
	logic               h_last;
	logic               v_last;

	// Scan state that belongs to a given counter pair
	function automatic video_pkg::scan_t scan_at(
		input video_pkg::hcount_t h,
		input video_pkg::vcount_t v
	);
		video_pkg::scan_t s;
		logic             h_in;
		logic             v_in;
		h_in = (h >= video_pkg::H_ACT_START) && (h < video_pkg::H_ACT_END);
		v_in = (v >= video_pkg::V_ACT_START) && (v < video_pkg::V_ACT_END);
		s.active = h_in && v_in;
		s.hsync  = (h >= video_pkg::H_SYNC);
		s.vsync  = (v >= video_pkg::V_SYNC);
		// Position inside the picture, zero elsewhere
		s.col = s.active ? h - video_pkg::H_ACT_START : '0;
		s.row = s.active ? v - video_pkg::V_ACT_START : '0;
		return s;
	endfunction

	////////////////////////////////////////////////////////////
	// Counter wrap
	////////////////////////////////////////////////////////////

	always_comb begin
		h_last = (hcount == video_pkg::H_TOTAL - 5'd1);
		v_last = (vcount == video_pkg::V_TOTAL - 4'd1);
		if (h_last) begin
			h_next = '0;
		end else begin
			h_next = hcount + 5'd1;
		end
		// Line advances only at the end of a line
		if (!h_last) begin
			v_next = vcount;
		end else if (v_last) begin
			v_next = '0;
		end else begin
			v_next = vcount + 4'd1;
		end
	end

	////////////////////////////////////////////////////////////
	// Counters and registered scan
	////////////////////////////////////////////////////////////

	// scan is loaded from the same next values as the counters,
	// so it always matches the count held in this cycle
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			hcount <= '0;
			vcount <= '0;
			scan   <= scan_at('0, '0);
		end else begin
			hcount <= h_next;
			vcount <= v_next;
			scan   <= scan_at(h_next, v_next);
		end
	end

endmodule
